// ==== hw/glb_geom_pkg.sv ====
// global buffer geometry
`default_nettype none

package glb_geom_pkg;

// bank count and bank index width
localparam int num_banks = 4;
localparam int num_banks_width = 2;

// word address inside one bank, 256 words deep
localparam int bank_addr_width = 8;
localparam int bank_depth = 1 << bank_addr_width;

// one bank word
localparam int bank_data_width = 64;

// soc port address, bank index sits above the word address
localparam int glb_addr_width = num_banks_width + bank_addr_width;

endpackage

`default_nettype wire

// ==== hw/glb_cfg_pkg.sv ====
// configuration register map
`default_nettype none

package glb_cfg_pkg;

import glb_geom_pkg::*;

// wishbone configuration port widths
localparam int cfg_addr_width = 16;
localparam int cfg_data_width = 32;

// top address bit picks register space or memory space
localparam logic cfg_space_reg = 1'b0;
localparam logic cfg_space_mem = 1'b1;

// per-bank register indices
localparam int cfg_reg_idx_width = 2;
localparam logic [cfg_reg_idx_width-1:0] cfg_reg_scratch = 2'd0;
localparam logic [cfg_reg_idx_width-1:0] cfg_reg_host_wr_count = 2'd1;
localparam logic [cfg_reg_idx_width-1:0] cfg_reg_cgra_wr_count = 2'd2;

// unused low bits of each address view
localparam int cfg_mem_pad_width = cfg_addr_width - 2 - num_banks_width - bank_addr_width;
localparam int cfg_reg_pad_width = cfg_addr_width - 1 - num_banks_width - cfg_reg_idx_width;

// config controller fsm encoding
localparam logic [1:0] cfg_st_idle = 2'd0;
localparam logic [1:0] cfg_st_wait = 2'd1;
localparam logic [1:0] cfg_st_ack = 2'd2;

// one config address, read either as a memory word or as a register
// space and bank fields line up in both views
typedef union packed {
    struct packed {
        logic                           space;
        logic [num_banks_width-1:0]     bank;
        logic [bank_addr_width-1:0]     word;
        logic                           upper;
        logic [cfg_mem_pad_width-1:0]   pad;
    } mem_view;
    struct packed {
        logic                           space;
        logic [num_banks_width-1:0]     bank;
        logic [cfg_reg_idx_width-1:0]   idx;
        logic [cfg_reg_pad_width-1:0]   pad;
    } reg_view;
} cfg_addr_u;

endpackage

`default_nettype wire

// ==== hw/host_bank_interface.sv ====
// soc port to bank host ports
`timescale 1ns/1ps
`default_nettype none

module host_bank_interface
    import glb_geom_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        soc_wr_en,
    input  logic [glb_addr_width-1:0]   soc_wr_addr,
    input  logic [bank_data_width-1:0]  soc_wr_data,

    input  logic                        soc_rd_en,
    input  logic [glb_addr_width-1:0]   soc_rd_addr,
    output logic [bank_data_width-1:0]  soc_rd_data,

    output logic                        host_wr_en [num_banks-1:0],
    output logic [bank_addr_width-1:0]  host_wr_addr [num_banks-1:0],
    output logic [bank_data_width-1:0]  host_wr_data [num_banks-1:0],

    output logic                        host_rd_en [num_banks-1:0],
    output logic [bank_addr_width-1:0]  host_rd_addr [num_banks-1:0],
    input  logic [bank_data_width-1:0]  host_rd_data [num_banks-1:0]
);

// bank index and word address of each soc access
logic [num_banks_width-1:0] wr_bank;
logic [bank_addr_width-1:0] wr_word;
logic [num_banks_width-1:0] rd_bank;
logic [bank_addr_width-1:0] rd_word;

// bank of the last issued read
logic [num_banks_width-1:0] rd_bank_q;

assign wr_bank = soc_wr_addr[glb_addr_width-1 -: num_banks_width];
assign wr_word = soc_wr_addr[bank_addr_width-1:0];
assign rd_bank = soc_rd_addr[glb_addr_width-1 -: num_banks_width];
assign rd_word = soc_rd_addr[bank_addr_width-1:0];

// only the decoded bank sees the access, the others get zeros
always_comb begin
    for (int b = 0; b < num_banks; b++) begin
        host_wr_en[b]   = soc_wr_en && (wr_bank == num_banks_width'(b));
        host_wr_addr[b] = host_wr_en[b] ? wr_word : '0;
        host_wr_data[b] = host_wr_en[b] ? soc_wr_data : '0;
        host_rd_en[b]   = soc_rd_en && (rd_bank == num_banks_width'(b));
        host_rd_addr[b] = host_rd_en[b] ? rd_word : '0;
    end
end

// remember which bank answers the read in flight
always_ff @(posedge clk) begin
    if (rst) begin
        rd_bank_q <= '0;
    end else if (soc_rd_en) begin
        rd_bank_q <= rd_bank;
    end
end

// banks hold their read data, so the mux output holds between reads
assign soc_rd_data = host_rd_data[rd_bank_q];

endmodule

`default_nettype wire

// ==== hw/memory_bank.sv ====
// dual-port memory bank
`timescale 1ns/1ps
`default_nettype none

module memory_bank
    import glb_geom_pkg::*;
    import glb_cfg_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        host_wr_en,
    input  logic [bank_addr_width-1:0]  host_wr_addr,
    input  logic [bank_data_width-1:0]  host_wr_data,
    input  logic                        host_rd_en,
    input  logic [bank_addr_width-1:0]  host_rd_addr,
    output logic [bank_data_width-1:0]  host_rd_data,

    input  logic                        cgra_wr_en,
    input  logic [bank_addr_width-1:0]  cgra_wr_addr,
    input  logic [bank_data_width-1:0]  cgra_wr_data,
    input  logic                        cgra_rd_en,
    input  logic [bank_addr_width-1:0]  cgra_rd_addr,
    output logic [bank_data_width-1:0]  cgra_rd_data,

    input  logic                        cfg_en,
    input  logic                        cfg_we,
    input  logic [cfg_addr_width-1:0]   cfg_addr,
    input  logic [cfg_data_width-1:0]   cfg_wr_data,
    output logic                        cfg_ack,
    output logic [cfg_data_width-1:0]   cfg_rd_data
);

logic [bank_data_width-1:0] bank_mem [bank_depth];

cfg_addr_u cfg_dec;
logic cfg_pending;
logic soc_idle;
logic reg_grant;
logic mem_grant;

// half-word access path
logic [bank_data_width-1:0] cfg_old_word;
logic [bank_data_width-1:0] cfg_new_word;
logic [cfg_data_width-1:0]  cfg_old_half;

// per-bank registers
logic [cfg_data_width-1:0] scratch;
logic [cfg_data_width-1:0] host_wr_count;
logic [cfg_data_width-1:0] cgra_wr_count;
logic [cfg_data_width-1:0] reg_rd_data;

assign cfg_dec = cfg_addr;

// no new grant in the ack cycle itself
assign cfg_pending = cfg_en && !cfg_ack;
assign soc_idle = !host_wr_en && !host_rd_en;

// registers answer right away, memory waits for a free host port
assign reg_grant = cfg_pending && (cfg_dec.reg_view.space == cfg_space_reg);
assign mem_grant = cfg_pending && (cfg_dec.mem_view.space == cfg_space_mem) && soc_idle;

// read-modify-write keeps the other half of the word
assign cfg_old_word = bank_mem[cfg_dec.mem_view.word];

always_comb begin
    if (cfg_dec.mem_view.upper) begin
        cfg_old_half = cfg_old_word[bank_data_width-1 -: cfg_data_width];
        cfg_new_word = {cfg_wr_data, cfg_old_word[cfg_data_width-1:0]};
    end else begin
        cfg_old_half = cfg_old_word[cfg_data_width-1:0];
        cfg_new_word = {cfg_old_word[bank_data_width-1 -: cfg_data_width], cfg_wr_data};
    end
end

// host port carries soc writes, or a config write when soc is idle
// cgra write goes last so it wins a same-address collision
always_ff @(posedge clk) begin
    if (host_wr_en) begin
        bank_mem[host_wr_addr] <= host_wr_data;
    end else if (mem_grant && cfg_we) begin
        bank_mem[cfg_dec.mem_view.word] <= cfg_new_word;
    end
    if (cgra_wr_en) begin
        bank_mem[cgra_wr_addr] <= cgra_wr_data;
    end
end

// read ports, data holds until the next read on that port
always_ff @(posedge clk) begin
    if (rst) begin
        host_rd_data <= '0;
        cgra_rd_data <= '0;
    end else begin
        if (host_rd_en) begin
            host_rd_data <= bank_mem[host_rd_addr];
        end
        if (cgra_rd_en) begin
            cgra_rd_data <= bank_mem[cgra_rd_addr];
        end
    end
end

// register read mux, index 3 reads as zero
always_comb begin
    case (cfg_dec.reg_view.idx)
        cfg_reg_scratch:       reg_rd_data = scratch;
        cfg_reg_host_wr_count: reg_rd_data = host_wr_count;
        cfg_reg_cgra_wr_count: reg_rd_data = cgra_wr_count;
        default:               reg_rd_data = '0;
    endcase
end

// scratch is writable, counters only count and wrap
always_ff @(posedge clk) begin
    if (rst) begin
        scratch <= '0;
        host_wr_count <= '0;
        cgra_wr_count <= '0;
    end else begin
        if (reg_grant && cfg_we && (cfg_dec.reg_view.idx == cfg_reg_scratch)) begin
            scratch <= cfg_wr_data;
        end
        if (host_wr_en) begin
            host_wr_count <= host_wr_count + 1'b1;
        end
        if (cgra_wr_en) begin
            cgra_wr_count <= cgra_wr_count + 1'b1;
        end
    end
end

// one-cycle ack, read data is zero outside it so banks can be ored
always_ff @(posedge clk) begin
    if (rst) begin
        cfg_ack <= 1'b0;
        cfg_rd_data <= '0;
    end else begin
        cfg_ack <= reg_grant || mem_grant;
        if (reg_grant) begin
            cfg_rd_data <= reg_rd_data;
        end else if (mem_grant) begin
            cfg_rd_data <= cfg_old_half;
        end else begin
            cfg_rd_data <= '0;
        end
    end
end

endmodule

`default_nettype wire

// ==== hw/glb_config_ctrl.sv ====
// wishbone configuration slave
`timescale 1ns/1ps
`default_nettype none

module glb_config_ctrl
    import glb_geom_pkg::*;
    import glb_cfg_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  logic [cfg_addr_width-1:0]   wb_adr,
    input  logic [cfg_data_width-1:0]   wb_dat_w,
    output logic [cfg_data_width-1:0]   wb_dat_r,
    output logic                        wb_ack,

    output logic                        cfg_en [num_banks-1:0],
    output logic                        cfg_we,
    output logic [cfg_addr_width-1:0]   cfg_addr,
    output logic [cfg_data_width-1:0]   cfg_wr_data,
    input  logic                        cfg_ack [num_banks-1:0],
    input  logic [cfg_data_width-1:0]   cfg_rd_data [num_banks-1:0]
);

logic [1:0] state;
cfg_addr_u adr_dec;
logic start;
logic any_ack;
logic [cfg_data_width-1:0] rd_merge;

// bank field is the same in both views
assign adr_dec = wb_adr;
assign start = (state == cfg_st_idle) && wb_cyc && wb_stb;

// idle banks drive zero data
always_comb begin
    any_ack = 1'b0;
    rd_merge = '0;
    for (int b = 0; b < num_banks; b++) begin
        any_ack = any_ack | cfg_ack[b];
        rd_merge = rd_merge | cfg_rd_data[b];
    end
end

// request payload, held for the whole bank access
always_ff @(posedge clk) begin
    if (start) begin
        cfg_we <= wb_we;
        cfg_addr <= wb_adr;
        cfg_wr_data <= wb_dat_w;
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        state <= cfg_st_idle;
        wb_ack <= 1'b0;
        wb_dat_r <= '0;
        for (int b = 0; b < num_banks; b++) begin
            cfg_en[b] <= 1'b0;
        end
    end else begin
        case (state)
            cfg_st_idle: begin
                // enable only the addressed bank
                if (start) begin
                    for (int b = 0; b < num_banks; b++) begin
                        cfg_en[b] <= (adr_dec.reg_view.bank == num_banks_width'(b));
                    end
                    state <= cfg_st_wait;
                end
            end
            cfg_st_wait: begin
                // bank may take a while in memory space
                if (any_ack) begin
                    for (int b = 0; b < num_banks; b++) begin
                        cfg_en[b] <= 1'b0;
                    end
                    wb_dat_r <= rd_merge;
                    // no ack to a master that already gave up
                    wb_ack <= wb_cyc && wb_stb;
                    state <= cfg_st_ack;
                end
            end
            cfg_st_ack: begin
                wb_ack <= 1'b0;
                state <= cfg_st_idle;
            end
            default: begin
                state <= cfg_st_idle;
            end
        endcase
    end
end

endmodule

`default_nettype wire

// ==== hw/global_buffer.sv ====
// global buffer top
`timescale 1ns/1ps
`default_nettype none

module global_buffer
    import glb_geom_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        soc_wr_en,
    input  logic [glb_addr_width-1:0]   soc_wr_addr,
    input  logic [bank_data_width-1:0]  soc_wr_data,
    input  logic                        soc_rd_en,
    input  logic [glb_addr_width-1:0]   soc_rd_addr,
    output logic [bank_data_width-1:0]  soc_rd_data,

    input  logic                        cgra_wr_en [num_banks-1:0],
    input  logic [bank_addr_width-1:0]  cgra_wr_addr [num_banks-1:0],
    input  logic [bank_data_width-1:0]  cgra_wr_data [num_banks-1:0],
    input  logic                        cgra_rd_en [num_banks-1:0],
    input  logic [bank_addr_width-1:0]  cgra_rd_addr [num_banks-1:0],
    output logic [bank_data_width-1:0]  cgra_rd_data [num_banks-1:0],

    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  logic [15:0]                 wb_adr,
    input  logic [31:0]                 wb_dat_w,
    output logic [31:0]                 wb_dat_r,
    output logic                        wb_ack
);

// host side of each bank
logic                       host_wr_en [num_banks-1:0];
logic [bank_addr_width-1:0] host_wr_addr [num_banks-1:0];
logic [bank_data_width-1:0] host_wr_data [num_banks-1:0];
logic                       host_rd_en [num_banks-1:0];
logic [bank_addr_width-1:0] host_rd_addr [num_banks-1:0];
logic [bank_data_width-1:0] host_rd_data [num_banks-1:0];

// configuration fan-out and per-bank returns
logic        cfg_en [num_banks-1:0];
logic        cfg_we;
logic [15:0] cfg_addr;
logic [31:0] cfg_wr_data;
logic        cfg_ack [num_banks-1:0];
logic [31:0] cfg_rd_data [num_banks-1:0];

host_bank_interface i_host_if (
    .clk            (clk),
    .rst            (rst),
    .soc_wr_en      (soc_wr_en),
    .soc_wr_addr    (soc_wr_addr),
    .soc_wr_data    (soc_wr_data),
    .soc_rd_en      (soc_rd_en),
    .soc_rd_addr    (soc_rd_addr),
    .soc_rd_data    (soc_rd_data),
    .host_wr_en     (host_wr_en),
    .host_wr_addr   (host_wr_addr),
    .host_wr_data   (host_wr_data),
    .host_rd_en     (host_rd_en),
    .host_rd_addr   (host_rd_addr),
    .host_rd_data   (host_rd_data)
);

// one bank per array column
for (genvar i = 0; i < num_banks; i++) begin : gen_bank
    memory_bank i_bank (
        .clk            (clk),
        .rst            (rst),
        .host_wr_en     (host_wr_en[i]),
        .host_wr_addr   (host_wr_addr[i]),
        .host_wr_data   (host_wr_data[i]),
        .host_rd_en     (host_rd_en[i]),
        .host_rd_addr   (host_rd_addr[i]),
        .host_rd_data   (host_rd_data[i]),
        .cgra_wr_en     (cgra_wr_en[i]),
        .cgra_wr_addr   (cgra_wr_addr[i]),
        .cgra_wr_data   (cgra_wr_data[i]),
        .cgra_rd_en     (cgra_rd_en[i]),
        .cgra_rd_addr   (cgra_rd_addr[i]),
        .cgra_rd_data   (cgra_rd_data[i]),
        .cfg_en         (cfg_en[i]),
        .cfg_we         (cfg_we),
        .cfg_addr       (cfg_addr),
        .cfg_wr_data    (cfg_wr_data),
        .cfg_ack        (cfg_ack[i]),
        .cfg_rd_data    (cfg_rd_data[i])
    );
end : gen_bank

glb_config_ctrl i_cfg_ctrl (
    .clk            (clk),
    .rst            (rst),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_we          (wb_we),
    .wb_adr         (wb_adr),
    .wb_dat_w       (wb_dat_w),
    .wb_dat_r       (wb_dat_r),
    .wb_ack         (wb_ack),
    .cfg_en         (cfg_en),
    .cfg_we         (cfg_we),
    .cfg_addr       (cfg_addr),
    .cfg_wr_data    (cfg_wr_data),
    .cfg_ack        (cfg_ack),
    .cfg_rd_data    (cfg_rd_data)
);

endmodule

`default_nettype wire

// ==== sim/global_buffer_sva.sv ====
// global buffer port assertions
`timescale 1ns/1ps
`default_nettype none

module global_buffer_sva
    import glb_geom_pkg::*;
(
    input logic                       clk,
    input logic                       rst,
    input logic                       wb_cyc,
    input logic                       wb_stb,
    input logic                       wb_ack,
    input logic                       cfg_en [num_banks-1:0],
    input logic                       cfg_ack [num_banks-1:0],
    input logic [bank_data_width-1:0] soc_rd_data,
    input logic [bank_data_width-1:0] cgra_rd_data [num_banks-1:0]
);

// ack is a one-cycle pulse
wb_ack_pulse: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
    else $error("wb_ack held longer than one cycle");

// no ack outside a live cycle
wb_ack_in_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |-> wb_cyc && wb_stb)
    else $error("wb_ack without cyc and stb");

soc_rd_reset: assert property (@(posedge clk) rst |=> soc_rd_data == '0)
    else $error("soc_rd_data not cleared by reset");

for (genvar b = 0; b < num_banks; b++) begin : gen_bank_chk
    // bank answers only its own request
    cfg_ack_in_en: assert property (@(posedge clk) disable iff (rst) cfg_ack[b] |-> cfg_en[b])
        else $error("cfg_ack without cfg_en on bank %0d", b);
    cgra_rd_reset: assert property (@(posedge clk) rst |=> cgra_rd_data[b] == '0)
        else $error("cgra_rd_data not cleared by reset on bank %0d", b);
end : gen_bank_chk

endmodule

bind global_buffer global_buffer_sva i_sva (
    .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack),
    .cfg_en(cfg_en), .cfg_ack(cfg_ack),
    .soc_rd_data(soc_rd_data), .cgra_rd_data(cgra_rd_data)
);

`default_nettype wire

// ==== sim/tb_global_buffer.sv ====
// global buffer testbench
`timescale 1ns/1ps
`default_nettype none

module tb_global_buffer
    import glb_geom_pkg::*;
    import glb_cfg_pkg::*;
();

localparam int fill_ops = num_banks * bank_depth;
localparam int soc_ops = 300;
localparam int mix_ops = 300;
localparam int reg_ops = 8 * num_banks;
localparam int mem_ops = 40;
localparam int wb_wait_max = 64;
// any single op may cost a full wishbone wait
localparam int timeout_cycles =
    (fill_ops + soc_ops + mix_ops + reg_ops + 3 * mem_ops) * wb_wait_max + 200;

logic                       clk;
logic                       rst;
logic                       soc_wr_en;
logic [glb_addr_width-1:0]  soc_wr_addr;
logic [bank_data_width-1:0] soc_wr_data;
logic                       soc_rd_en;
logic [glb_addr_width-1:0]  soc_rd_addr;
logic [bank_data_width-1:0] soc_rd_data;
logic                       cgra_wr_en [num_banks-1:0];
logic [bank_addr_width-1:0] cgra_wr_addr [num_banks-1:0];
logic [bank_data_width-1:0] cgra_wr_data [num_banks-1:0];
logic                       cgra_rd_en [num_banks-1:0];
logic [bank_addr_width-1:0] cgra_rd_addr [num_banks-1:0];
logic [bank_data_width-1:0] cgra_rd_data [num_banks-1:0];
logic                       wb_cyc;
logic                       wb_stb;
logic                       wb_we;
logic [cfg_addr_width-1:0]  wb_adr;
logic [cfg_data_width-1:0]  wb_dat_w;
logic [cfg_data_width-1:0]  wb_dat_r;
logic                       wb_ack;

// reference model memory indexed by the full soc address
logic [bank_data_width-1:0] model_mem [num_banks*bank_depth];
logic [cfg_data_width-1:0]  model_scratch [num_banks];
logic [cfg_data_width-1:0]  model_host_cnt [num_banks];
logic [cfg_data_width-1:0]  model_cgra_cnt [num_banks];

logic [63:0]               rng_state;
int                        cycle_count = 0;
// word that random soc traffic must not touch
logic                      avoid_on;
logic [glb_addr_width-1:0] avoid_addr;
// word of the last forced collision, read back on the next cycle
logic                      collide_pend;
logic [glb_addr_width-1:0] collide_addr;

global_buffer i_dut (
    .clk(clk), .rst(rst),
    .soc_wr_en(soc_wr_en), .soc_wr_addr(soc_wr_addr), .soc_wr_data(soc_wr_data),
    .soc_rd_en(soc_rd_en), .soc_rd_addr(soc_rd_addr), .soc_rd_data(soc_rd_data),
    .cgra_wr_en(cgra_wr_en), .cgra_wr_addr(cgra_wr_addr), .cgra_wr_data(cgra_wr_data),
    .cgra_rd_en(cgra_rd_en), .cgra_rd_addr(cgra_rd_addr), .cgra_rd_data(cgra_rd_data),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
);

initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
end

// run limit
always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > timeout_cycles) begin
        $display("timeout, the tests did not finish within %0d cycles", timeout_cycles);
        $display("Regression failed");
        $fatal(1, "run limit reached");
    end
end

// xorshift64 step
function automatic logic [63:0] rand64();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 7);
    rng_state = rng_state ^ (rng_state << 17);
    return rng_state;
endfunction

// initial contents where every address bit shows up in the word
function automatic logic [63:0] fill_word(input logic [glb_addr_width-1:0] a);
    return {a, ~a, a, ~a, a, ~a, 4'h5};
endfunction

function automatic logic [cfg_addr_width-1:0] cfg_reg_addr(input int bank,
                                                          input logic [1:0] idx);
    cfg_addr_u a;
    a = '0;
    a.reg_view.space = cfg_space_reg;
    a.reg_view.bank = num_banks_width'(bank);
    a.reg_view.idx = idx;
    return a;
endfunction

function automatic logic [cfg_addr_width-1:0] cfg_mem_addr(input logic [1:0] bank,
        input logic [bank_addr_width-1:0] word, input logic upper);
    cfg_addr_u a;
    a = '0;
    a.mem_view.space = cfg_space_mem;
    a.mem_view.bank = bank;
    a.mem_view.word = word;
    a.mem_view.upper = upper;
    return a;
endfunction

task automatic check_value(input string test, input logic [63:0] expected,
                           input logic [63:0] actual);
    if (expected !== actual) begin
        $display("Fail %s expected %h actual %h", test, expected, actual);
        $display("Regression failed");
        $fatal(1, "mismatch");
    end
endtask

task automatic clear_traffic();
    soc_wr_en = 1'b0;
    soc_wr_addr = '0;
    soc_wr_data = '0;
    soc_rd_en = 1'b0;
    soc_rd_addr = '0;
    for (int b = 0; b < num_banks; b++) begin
        cgra_wr_en[b] = 1'b0;
        cgra_wr_addr[b] = '0;
        cgra_wr_data[b] = '0;
        cgra_rd_en[b] = 1'b0;
        cgra_rd_addr[b] = '0;
    end
endtask

task automatic randomize_traffic(input bit soc_on, input bit cgra_on, input bit collide);
    logic [63:0] r;
    logic [63:0] c;
    logic [num_banks_width-1:0] bank;
    r = rand64();
    soc_wr_en = soc_on && r[0];
    soc_rd_en = soc_on && r[1];
    soc_wr_addr = r[2 +: glb_addr_width];
    soc_rd_addr = r[12 +: glb_addr_width];
    soc_wr_data = rand64();
    if (collide && r[22]) begin
        soc_rd_addr = soc_wr_addr;
    end
    // winner of the previous collision seen through the soc port
    if (collide && collide_pend) begin
        soc_rd_en = 1'b1;
        soc_rd_addr = collide_addr;
        collide_pend = 1'b0;
    end
    // flip the low bit to step off the word under config access
    if (avoid_on && soc_wr_addr == avoid_addr) begin
        soc_wr_addr[0] = ~soc_wr_addr[0];
    end
    if (avoid_on && soc_rd_addr == avoid_addr) begin
        soc_rd_addr[0] = ~soc_rd_addr[0];
    end
    for (int b = 0; b < num_banks; b++) begin
        c = rand64();
        cgra_wr_en[b] = cgra_on && c[0];
        cgra_rd_en[b] = cgra_on && c[1];
        cgra_wr_addr[b] = c[2 +: bank_addr_width];
        cgra_rd_addr[b] = c[c[18] ? 2 : 10 +: bank_addr_width];
        cgra_wr_data[b] = rand64();
    end
    // forced host/cgra write to one word
    if (collide && cgra_on && soc_wr_en && r[23]) begin
        bank = soc_wr_addr[glb_addr_width-1 -: num_banks_width];
        cgra_wr_en[bank] = 1'b1;
        cgra_wr_addr[bank] = soc_wr_addr[bank_addr_width-1:0];
        cgra_rd_en[bank] = r[24];
        cgra_rd_addr[bank] = cgra_wr_addr[bank];
        collide_pend = 1'b1;
        collide_addr = soc_wr_addr;
    end
endtask

// one clock of traffic with the model updated from the driven inputs
task automatic step_cycle(input string test);
    logic [63:0] exp_soc;
    logic [63:0] exp_cgra [num_banks];
    logic        chk_soc;
    logic        chk_cgra [num_banks];
    logic [num_banks_width-1:0] bank;
    chk_soc = soc_rd_en;
    exp_soc = model_mem[soc_rd_addr];
    for (int b = 0; b < num_banks; b++) begin
        chk_cgra[b] = cgra_rd_en[b];
        exp_cgra[b] = model_mem[{num_banks_width'(b), cgra_rd_addr[b]}];
    end
    // reads see the old word and cgra writes land on top of host writes
    if (soc_wr_en) begin
        bank = soc_wr_addr[glb_addr_width-1 -: num_banks_width];
        model_mem[soc_wr_addr] = soc_wr_data;
        model_host_cnt[bank] = model_host_cnt[bank] + 1;
    end
    for (int b = 0; b < num_banks; b++) begin
        if (cgra_wr_en[b]) begin
            model_mem[{num_banks_width'(b), cgra_wr_addr[b]}] = cgra_wr_data[b];
            model_cgra_cnt[b] = model_cgra_cnt[b] + 1;
        end
    end
    @(posedge clk);
    @(negedge clk);
    if (chk_soc) begin
        check_value({test, " soc read"}, exp_soc, soc_rd_data);
    end
    for (int b = 0; b < num_banks; b++) begin
        if (chk_cgra[b]) begin
            check_value($sformatf("%s cgra%0d read", test, b), exp_cgra[b], cgra_rd_data[b]);
        end
    end
endtask

task automatic wb_transfer(input string test, input logic we,
        input logic [cfg_addr_width-1:0] adr, input logic [cfg_data_width-1:0] wdata,
        input bit traffic, output logic [cfg_data_width-1:0] rdata);
    bit got_ack;
    got_ack = 1'b0;
    rdata = '0;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_dat_w = wdata;
    while (!got_ack) begin
        randomize_traffic(traffic, 1'b0, 1'b0);
        step_cycle(test);
        if (wb_ack) begin
            got_ack = 1'b1;
            rdata = wb_dat_r;
        end
    end
    // master takes the ack on the next edge and then drops the cycle
    randomize_traffic(traffic, 1'b0, 1'b0);
    step_cycle(test);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    clear_traffic();
endtask

initial begin
    logic [cfg_data_width-1:0]  rdata;
    logic [cfg_data_width-1:0]  exp_half;
    logic [63:0]                r;
    logic [num_banks_width-1:0] bank;
    logic [bank_addr_width-1:0] word;
    logic                       upper;
    logic [glb_addr_width-1:0]  target;

    rng_state = 64'd93;
    avoid_on = 1'b0;
    avoid_addr = '0;
    collide_pend = 1'b0;
    collide_addr = '0;
    for (int b = 0; b < num_banks; b++) begin
        model_scratch[b] = '0;
        model_host_cnt[b] = '0;
        model_cgra_cnt[b] = '0;
    end
    rst = 1'b1;
    clear_traffic();
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // outputs and counters straight out of reset
    check_value("reset soc_rd_data", '0, soc_rd_data);
    check_value("reset wb_ack", '0, 64'(wb_ack));
    for (int b = 0; b < num_banks; b++) begin
        check_value("reset cgra_rd_data", '0, cgra_rd_data[b]);
        wb_transfer("reset host count", 1'b0, cfg_reg_addr(b, cfg_reg_host_wr_count),
                    '0, 1'b0, rdata);
        check_value("reset host count", '0, 64'(rdata));
        wb_transfer("reset cgra count", 1'b0, cfg_reg_addr(b, cfg_reg_cgra_wr_count),
                    '0, 1'b0, rdata);
        check_value("reset cgra count", '0, 64'(rdata));
    end

    // known contents everywhere before random reads
    for (int a = 0; a < fill_ops; a++) begin
        soc_wr_en = 1'b1;
        soc_wr_addr = glb_addr_width'(a);
        soc_wr_data = fill_word(glb_addr_width'(a));
        step_cycle("fill");
    end
    clear_traffic();

    repeat (soc_ops) begin
        randomize_traffic(1'b1, 1'b0, 1'b0);
        step_cycle("soc_random");
    end
    repeat (mix_ops) begin
        randomize_traffic(1'b1, 1'b1, 1'b1);
        step_cycle("cgra_mixed");
    end
    clear_traffic();

    // register space scratch per bank and both counters
    for (int b = 0; b < num_banks; b++) begin
        r = rand64();
        model_scratch[b] = r[31:0];
        wb_transfer("wb_regs scratch write", 1'b1, cfg_reg_addr(b, cfg_reg_scratch),
                    r[31:0], 1'b0, rdata);
    end
    for (int b = 0; b < num_banks; b++) begin
        wb_transfer("wb_regs scratch", 1'b0, cfg_reg_addr(b, cfg_reg_scratch), '0, 1'b0, rdata);
        check_value("wb_regs scratch", 64'(model_scratch[b]), 64'(rdata));
        wb_transfer("wb_regs host count", 1'b0, cfg_reg_addr(b, cfg_reg_host_wr_count),
                    '0, 1'b0, rdata);
        check_value("wb_regs host count", 64'(model_host_cnt[b]), 64'(rdata));
        wb_transfer("wb_regs cgra count", 1'b0, cfg_reg_addr(b, cfg_reg_cgra_wr_count),
                    '0, 1'b0, rdata);
        check_value("wb_regs cgra count", 64'(model_cgra_cnt[b]), 64'(rdata));
    end

    // memory space half-word access under soc traffic
    repeat (mem_ops) begin
        r = rand64();
        bank = r[0 +: num_banks_width];
        word = r[8 +: bank_addr_width];
        upper = r[20];
        target = {bank, word};
        avoid_on = 1'b1;
        avoid_addr = target;
        wb_transfer("wb_mem write", 1'b1, cfg_mem_addr(bank, word, upper), r[63:32], 1'b1, rdata);
        if (upper) begin
            model_mem[target][63:32] = r[63:32];
        end else begin
            model_mem[target][31:0] = r[63:32];
        end
        upper = r[21];
        wb_transfer("wb_mem read", 1'b0, cfg_mem_addr(bank, word, upper), '0, 1'b1, rdata);
        exp_half = upper ? model_mem[target][63:32] : model_mem[target][31:0];
        check_value("wb_mem read", 64'(exp_half), 64'(rdata));
        avoid_on = 1'b0;
        // whole word seen from the soc side
        soc_rd_en = 1'b1;
        soc_rd_addr = target;
        step_cycle("wb_mem soc readback");
        clear_traffic();
    end

    step_cycle("idle");
    $display("Regression passed");
    $finish;
end

endmodule

`default_nettype wire

// ==== vlog.f ====
hw/glb_geom_pkg.sv
hw/glb_cfg_pkg.sv
hw/host_bank_interface.sv
hw/memory_bank.sv
hw/glb_config_ctrl.sv
hw/global_buffer.sv
sim/global_buffer_sva.sv
sim/tb_global_buffer.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the global buffer regression with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module tb_global_buffer -o tb_global_buffer \
    && ./obj_dir/tb_global_buffer > sim.log 2>&1

# the log decides pass or fail
grep -q "Regression passed" sim.log 2>/dev/null \
    && echo "PASS" \
    || { echo "FAIL, see sim.log"; exit 1; }
